//--- compile.f
source/ram_pkg.sv
source/sram_bus_if.sv
source/sram_4kx4.sv
source/sram_bank.sv
source/bank_decoder.sv
source/memory_top.sv
sim/memory_chk.sv
sim/memory_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the memory board testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f compile.f \
  --top-module memory_tb -Mdir "$OBJ" -o memory_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/memory_tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q -x '\*\* PASS \*\*' "$LOG"; then
  echo "Result: simulation passed"
  exit 0
else
  echo "Result: simulation failed, see $LOG"
  exit 1
fi

//--- sim/memory_chk.sv
//####################################################################
// Memory chip checker
// Output gating and write blocking in reset, bound into every chip
//####################################################################

`timescale 1ns/1ps

module memory_chk (
  input logic                            clk,
  input logic                            reset_n,
  input logic [ram_pkg::chip_addr_w-1:0] addr,
  input logic                            ce_n,
  input logic                            we_n,
  input logic [ram_pkg::nibble_w-1:0]    dout,
  input logic [ram_pkg::nibble_w-1:0]    mem_array [ram_pkg::chip_depth]
);

  int fail_cnt = 0; // Assertion failures in this chip

  // Gate opens only after a selected edge out of reset, and only while not writing
  gated_zero: assert property (@(posedge clk) disable iff (!reset_n)
    !($past(reset_n) && !$past(ce_n) && we_n) |-> dout == '0)
    else begin
      $error("chip output nonzero with gate closed");
      fail_cnt++;
    end

  // Cell under the address untouched by an edge in reset
  no_reset_write: assert property (@(posedge clk)
    !reset_n |=> mem_array[$past(addr)] === $past(mem_array[addr]))
    else begin
      $error("chip cell changed while in reset");
      fail_cnt++;
    end

endmodule

bind sram_4kx4 memory_chk chk0 (
  .clk       (clk),
  .reset_n   (reset_n),
  .addr      (addr),
  .ce_n      (ce_n),
  .we_n      (we_n),
  .dout      (dout),
  .mem_array (mem_array)
);

//--- sim/memory_tb.sv
//####################################################################
// Memory board testbench
// Directed tests against a reference array, LFSR data, one-cycle reads
//####################################################################

`timescale 1ns/1ps

module memory_tb;

  import ram_pkg::*;

  localparam int bank_count = 2;
  localparam int addr_w     = chip_addr_w + $clog2(bank_count); // 13 bits
  localparam int mem_words  = 1 << addr_w;
  localparam int chip_count = bank_count * chips_per_bank;
  localparam mem_word_u zero_word = '0;

  logic              clk;
  logic              reset_n;
  logic              cs;
  logic              we;
  logic [addr_w-1:0] addr;
  logic [word_w-1:0] wdata;
  logic [word_w-1:0] rdata;
  mem_word_u         rd_u;     // rdata seen through the union

  mem_word_u         ref_mem [mem_words]; // Expected contents
  logic [addr_w-1:0] written_q [$];       // Every address written so far
  logic [15:0]       lfsr_state = 16'd10394;
  int                check_cnt   = 0;
  int                err_cnt     = 0;
  int                assert_cnt;
  logic [chip_count-1:0][31:0] chk_fail;   // Assertion failures per chip

  memory_top #(
    .BANK_COUNT (bank_count)
  ) dut0 (
    .clk     (clk),
    .reset_n (reset_n),
    .cs      (cs),
    .we      (we),
    .addr    (addr),
    .wdata   (wdata),
    .rdata   (rdata)
  );

  assign rd_u.word = rdata;

  // Failure counters of the bound checkers
  for (genvar b = 0; b < bank_count; b++) begin : g_chk_bank
    for (genvar c = 0; c < chips_per_bank; c++) begin : g_chk_chip
      assign chk_fail[b*chips_per_bank+c] =
        dut0.g_bank[b].u_bank.g_chip[c].u_chip.chk0.fail_cnt;
    end
  end

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  // Fibonacci LFSR, taps 16 14 13 11, one step per bit taken
  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      r          = {r[14:0], fb};
    end
    return r;
  endfunction

  task automatic check_word(input mem_word_u got, input mem_word_u exp, input string what);
    check_cnt++;
    if (got.word !== exp.word) begin
      err_cnt++;
      $display("ERR @ %0t ns: %s returned %h, expected %h", $time, what, got.word, exp.word);
    end
  endtask

  task automatic next_fall;
    @(negedge clk); // Inputs change here, outputs are stable here
  endtask

  task automatic drive_write(input logic [addr_w-1:0] a, input logic [word_w-1:0] d);
    cs    = 1'b1;
    we    = 1'b1;
    addr  = a;
    wdata = d;
    ref_mem[a].word = d; // Reference follows every write issued
    written_q.push_back(a);
  endtask

  task automatic drive_read(input logic [addr_w-1:0] a);
    cs   = 1'b1;
    we   = 1'b0;
    addr = a;
  endtask

  task automatic write_word(input logic [addr_w-1:0] a, input logic [word_w-1:0] d);
    drive_write(a, d);
    next_fall;
  endtask

  // Read addressed at the next rising edge, data checked one cycle later
  task automatic read_check(input logic [addr_w-1:0] a, input string what);
    drive_read(a);
    next_fall;
    check_word(rd_u, ref_mem[a], what);
  endtask

  // Reset with a write attempt, then a read presented with cs high
  task automatic reset_then_read_zero;
    reset_n = 1'b0;
    cs      = 1'b1;
    we      = 1'b1;
    addr    = addr_w'(32'h0015);
    wdata   = 16'hA5A5; // Must not reach the cells
    for (int i = 0; i < 5; i++) begin
      next_fall;
      if (i == 1) begin
        we = 1'b0;
      end
    end
    check_word(rd_u, zero_word, "read during reset");
    reset_n = 1'b1;
    cs      = 1'b0;
    next_fall;
    check_word(rd_u, zero_word, "idle after reset");
  endtask

  // Same low bits in both banks, different words
  task automatic test_both_banks;
    logic [addr_w-1:0] lo_a;
    logic [addr_w-1:0] hi_a;
    logic [15:0]       r;
    logic [15:0]       d;
    logic [addr_w-1:0] lo_q [$];
    for (int k = 0; k < 8; k++) begin
      r    = take_bits(chip_addr_w);
      lo_a = '0;
      lo_a[chip_addr_w-1:0] = r[chip_addr_w-1:0];
      hi_a = lo_a;
      hi_a[chip_addr_w] = 1'b1; // Only the bank bit differs
      d = take_bits(word_w);
      write_word(lo_a, d);
      write_word(hi_a, ~d);
      lo_q.push_back(lo_a);
    end
    foreach (lo_q[k]) begin
      hi_a = lo_q[k];
      hi_a[chip_addr_w] = 1'b1;
      read_check(lo_q[k], "bank 0 word");
      read_check(hi_a, "bank 1 word");
    end
  endtask

  // One lit nibble per word, one chip at a time
  task automatic test_nibble_lanes;
    logic [15:0] pat [4] = '{16'h000F, 16'h00F0, 16'h0F00, 16'hF000};
    for (int i = 0; i < 4; i++) begin
      write_word(addr_w'(32'h0100 + i), pat[i]);
      write_word(addr_w'((1 << chip_addr_w) + 32'h0100 + i), ~pat[i]);
    end
    for (int i = 0; i < 4; i++) begin
      read_check(addr_w'(32'h0100 + i), "nibble pattern");
      read_check(addr_w'((1 << chip_addr_w) + 32'h0100 + i), "inverted nibble pattern");
    end
  endtask

  // Deselected reads and write cycles give zero
  task automatic test_zero_gating;
    write_word(addr_w'(32'h0200), 16'h5A3C);
    read_check(addr_w'(32'h0200), "word before cs low read");
    cs = 1'b0;
    we = 1'b0;
    next_fall;
    check_word(rd_u, zero_word, "read with cs low");
    read_check(addr_w'(32'h0200), "word before write cycle");
    drive_write(addr_w'(32'h1201), 16'hC3A5);
    next_fall;
    check_word(rd_u, zero_word, "write cycle");
    read_check(addr_w'(32'h1201), "word after write cycle");
  endtask

  // 200 random writes, then 200 reads on every cycle
  task automatic test_burst;
    logic [15:0] r;
    int          base;
    int          idx;
    for (int k = 0; k < 200; k++) begin
      r = take_bits(addr_w);
      write_word(r[addr_w-1:0], take_bits(word_w));
    end
    base = written_q.size() - 200;
    for (int k = 0; k < 200; k++) begin
      idx = base + (int'(take_bits(8)) % 200);
      read_check(written_q[idx], "burst read");
    end
  endtask

  // Read right behind a write to the same address
  task automatic test_write_then_read;
    logic [15:0] r;
    for (int k = 0; k < 6; k++) begin
      r = take_bits(addr_w);
      write_word(r[addr_w-1:0], take_bits(word_w));
      read_check(r[addr_w-1:0], "read right after write");
    end
  endtask

  initial begin
    reset_n = 1'b0;
    cs      = 1'b0;
    we      = 1'b0;
    addr    = '0;
    wdata   = '0;
    reset_then_read_zero();
    test_both_banks();
    test_nibble_lanes();
    test_zero_gating();
    test_burst();
    test_write_then_read();
    cs = 1'b0;
    we = 1'b0;
    next_fall;
    assert_cnt = 0;
    for (int i = 0; i < chip_count; i++) begin
      assert_cnt += int'(chk_fail[i]);
    end
    $display("Checks %0d  value errors %0d  assertion failures %0d",
             check_cnt, err_cnt, assert_cnt);
    if (err_cnt == 0 && assert_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- source/bank_decoder.sv
//####################################################################
// Bank decoder
// Turns processor strobes into per bank enables and merges bank data
//####################################################################

`timescale 1ns/1ps

module bank_decoder #(
  parameter  int BANK_COUNT  = 2,  // Power of two
  localparam int bank_sel_w  = $clog2(BANK_COUNT),
  localparam int proc_addr_w = ram_pkg::chip_addr_w + bank_sel_w
) (
  input  logic                   cs,     // Select, active high
  input  logic                   we,     // Write, active high
  input  logic [proc_addr_w-1:0] addr,   // Processor address
  input  ram_pkg::mem_word_u     wdata,
  output ram_pkg::mem_word_u     rdata,  // OR of all bank outputs
  sram_bus_if.master             banks [BANK_COUNT]
);

  import ram_pkg::*;

  logic [bank_sel_w-1:0]  bank_sel;   // High address bits pick the bank
  logic [chip_addr_w-1:0] chip_addr;  // Low bits go to every bank
  logic                   we_n;
  mem_word_u              bank_rd [BANK_COUNT]; // Collected bank outputs

  assign bank_sel  = addr[proc_addr_w-1:chip_addr_w];
  assign chip_addr = addr[chip_addr_w-1:0];
  assign we_n      = ~we;  // Shared, the enables keep other banks idle

  for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
    // Only the addressed bank is enabled, and only with cs high
    assign banks[b].ce_n  = ~(cs && (bank_sel == bank_sel_w'(b)));
    assign banks[b].addr  = chip_addr;
    assign banks[b].we_n  = we_n;
    assign banks[b].wdata = wdata;   // Same word to all banks
    assign bank_rd[b]     = banks[b].rdata;
  end

  // Merge bank outputs
  // Unselected banks drive zero so a plain OR is exact
  always_comb begin
    rdata.word = '0;
    for (int b = 0; b < BANK_COUNT; b++) begin
      rdata.word = rdata.word | bank_rd[b].word;
    end
  end

endmodule

//--- source/memory_top.sv
//####################################################################
// ND120 style memory board
// Processor side 16 bit port over BANK_COUNT banks of 4K x 16
//####################################################################

`timescale 1ns/1ps

module memory_top #(
  parameter  int BANK_COUNT  = 2,
  localparam int proc_addr_w = ram_pkg::chip_addr_w + $clog2(BANK_COUNT)
) (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       cs,     // Board select, active high
  input  logic                       we,     // Write, active high
  input  logic [proc_addr_w-1:0]     addr,
  input  logic [ram_pkg::word_w-1:0] wdata,
  output logic [ram_pkg::word_w-1:0] rdata   // One cycle after read edge
);

  import ram_pkg::*;

  mem_word_u wdata_u;
  mem_word_u rdata_u;

  assign wdata_u.word = wdata;
  assign rdata        = rdata_u.word;

  // One bus per bank
  sram_bus_if bank_bus [BANK_COUNT] ();

  bank_decoder #(
    .BANK_COUNT (BANK_COUNT)
  ) u_decoder (
    .cs    (cs),
    .we    (we),
    .addr  (addr),
    .wdata (wdata_u),
    .rdata (rdata_u),
    .banks (bank_bus)
  );

  for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
    sram_bank u_bank (
      .clk     (clk),
      .reset_n (reset_n),
      .bus     (bank_bus[b])
    );
  end

endmodule

//--- source/ram_pkg.sv
//####################################################################
// Memory board shared definitions
// Chip and bank widths, address split and the bank data word
//####################################################################

package ram_pkg;

  // One static RAM chip, 4K x 4
  localparam int chip_addr_w = 12;              // Address bits per chip
  localparam int chip_depth  = 1 << chip_addr_w; // 4096 nibbles
  localparam int nibble_w    = 4;               // Chip data width

  // One bank, chips side by side
  localparam int chips_per_bank = 4;
  localparam int word_w         = chips_per_bank * nibble_w; // 16 bit word

  // Bank data word
  // Seen whole by the processor side, as nibbles by the chips
  // Nibble 0 is the least significant and belongs to chip 0
  typedef union packed {
    logic [word_w-1:0]                       word;
    logic [chips_per_bank-1:0][nibble_w-1:0] nib;
  } mem_word_u;

endpackage

//--- source/sram_4kx4.sv
//####################################################################
// 4K x 4 static RAM chip, block RAM model
// Clocked write and read, registered output gated by enables
//####################################################################

`timescale 1ns/1ps

module sram_4kx4 (
  input  logic                         clk,
  input  logic                         reset_n,
  input  logic [ram_pkg::chip_addr_w-1:0] addr,  // Cell address
  input  logic                         ce_n,     // Chip enable, active low
  input  logic                         we_n,     // Write enable, active low
  input  logic [ram_pkg::nibble_w-1:0] din,      // Write data
  output logic [ram_pkg::nibble_w-1:0] dout      // Zero unless read selected
);

  import ram_pkg::*;

  logic [nibble_w-1:0] mem_array [chip_depth]; // Cell storage, no reset
  logic [nibble_w-1:0] rd_q;                   // Read register
  logic                ce_n_q;                 // Enable seen at last edge

  // Storage write
  // Data stored is the data present at this same edge
  always_ff @(posedge clk) begin
    if (reset_n && !ce_n && !we_n) begin
      mem_array[addr] <= din;
    end
  end

  // Read register and registered enable
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      rd_q   <= '0;
      ce_n_q <= 1'b1;  // Deselected after reset
    end else begin
      ce_n_q <= ce_n;  // Tracked every cycle, selected or not
      if (!ce_n && we_n) begin
        rd_q <= mem_array[addr]; // Read cycle
      end
    end
  end

  // Output only after a selected cycle and while not writing
  // Keeps unselected chips at zero so bank outputs can be ORed
  always_comb begin
    if (!ce_n_q && we_n) begin
      dout = rd_q;
    end else begin
      dout = '0;
    end
  end

endmodule

//--- source/sram_bank.sv
//####################################################################
// 4K x 16 memory bank
// Four 4K x 4 chips side by side, one nibble of the word each
//####################################################################

`timescale 1ns/1ps

module sram_bank (
  input  logic       clk,
  input  logic       reset_n,
  sram_bus_if.slave  bus      // Address, enables and data from decoder
);

  import ram_pkg::*;

  logic [nibble_w-1:0] chip_dout [chips_per_bank]; // Per chip gated output
  mem_word_u           rd_word;                    // Joined read word

  // One chip per nibble
  // All chips see the same address and enables
  for (genvar i = 0; i < chips_per_bank; i++) begin : g_chip
    sram_4kx4 u_chip (
      .clk     (clk),
      .reset_n (reset_n),
      .addr    (bus.addr),
      .ce_n    (bus.ce_n),
      .we_n    (bus.we_n),
      .din     (bus.wdata.nib[i]),  // Nibble i to chip i
      .dout    (chip_dout[i])
    );
  end

  // Join chip outputs back into one word
  always_comb begin
    rd_word.word = '0;
    for (int i = 0; i < chips_per_bank; i++) begin
      rd_word.nib[i] = chip_dout[i];
    end
  end

  assign bus.rdata = rd_word; // Zero when bank not read

endmodule

//--- source/sram_bus_if.sv
//####################################################################
// Bank bus
// Address, active low enables and data between decoder and one bank
//####################################################################

`timescale 1ns/1ps

interface sram_bus_if;

  import ram_pkg::*;

  logic [chip_addr_w-1:0] addr;  // Chip address, low processor bits
  logic                   ce_n;  // Bank select, active low
  logic                   we_n;  // Write strobe, active low
  mem_word_u              wdata; // Word to store
  mem_word_u              rdata; // Gated read word from the chips

  // Decoder side
  modport master (
    output addr,
    output ce_n,
    output we_n,
    output wdata,
    input  rdata
  );

  // Bank side
  modport slave (
    input  addr,
    input  ce_n,
    input  we_n,
    input  wdata,
    output rdata
  );

endinterface
